// ==== tb.f ====
hdl/bridge_pkg.sv
hdl/reset_sequencer.sv
hdl/cpu_index_tracker.sv
hdl/thread_base_regs.sv
hdl/token_arbiter.sv
hdl/bridge_top.sv
tb/tb_bridge.sv

// ==== Makefile ====
TOP = tb_bridge

all: run

build:
	verilator --binary --timing -f tb.f --top-module $(TOP)

run: build
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qF '*** TEST PASSED ***'

lint:
	verilator --lint-only --timing -f tb.f --top-module $(TOP)

clean:
	rm -rf obj_dir

.PHONY: all build run lint clean

// ==== tb/tb_bridge.sv ====
`timescale 1ns/1ns

module tb_bridge;

  import bridge_pkg::*;

  localparam int LIMIT = 4000;

  logic clk, ext_rst_b, read_q, write_q, ext_next_cpu_q, bus_busy_in;
  logic [STATE_W-1:0] state;
  logic [ADDR_W-1:0] addr_in;
  logic [DATA_W-1:0] data_in;
  cpu_index_t ext_cpu_index;
  logic [CPU_MSG_W-1:0] ext_cpu_msg_in, ext_cpu_msg;
  logic ext_next_cpu_e, ext_read_q, ext_write_q, ext_dispatcher_q, next_state;
  logic rst, ext_rst_e, bus_busy_out, disp_online;
  logic [1:0] cpu_ind_rel;
  logic [ADDR_W-1:0] base_addr, base_addr_data;

  // reference model state
  logic [2:0] m_step;
  logic m_done, m_rst, m_erst, m_online, m_e, m_ns, m_dq, m_restart, m_grant;
  logic [1:0] m_rel;
  logic [CPU_MSG_W-1:0] m_msg;
  logic [ADDR_W-1:0] m_base, m_based;
  cpu_index_t m_idx;

  string test_name;
  int errors, checks, tests, test_start_errors, cycles;
  logic [STATE_W-1:0] core_states [16];

  bridge_top DUT (.*);

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  function automatic logic is_rd(logic [STATE_W-1:0] st);
    return st inside {ST_READ_COND, ST_READ_COND_P, ST_READ_SRC1, ST_READ_SRC1_P,
                      ST_READ_SRC0, ST_READ_SRC0_P, ST_READ_DST, ST_START_READ_CMD,
                      ST_START_READ_CMD_P};
  endfunction

  function automatic logic is_wr(logic [STATE_W-1:0] st);
    return st inside {ST_WRITE_REG_IP, ST_WRITE_DST, ST_WRITE_DST_P, ST_WRITE_SRC1,
                      ST_WRITE_SRC0, ST_WRITE_COND};
  endfunction

  // small positions so that orderings collide often
  function automatic cpu_index_t rand_index();
    cpu_index_t v;
    v.split.active = 1'($urandom);
    v.split.pos    = 31'($urandom % 8);
    return v;
  endfunction

  assign m_restart = m_done && (state == ST_FINISH_END);
  assign m_grant   = ext_next_cpu_q && (ext_cpu_index.raw == m_idx.raw);

  always @(posedge clk) begin
    if (ext_rst_b) begin
      m_step <= 3'd1;
      {m_done, m_rst, m_erst, m_online, m_e, m_ns, m_dq} <= '0;
      m_rel <= 2'b00;
      m_msg <= MSG_NONE;
      m_idx.raw <= '0;
      m_base <= '0;
      m_based <= '0;
    end else begin
      // sequencer steps
      m_rst  <= 1'b0;
      m_erst <= 1'b0;
      case (m_step)
        3'd1: m_step <= 3'd2;
        3'd2: m_step <= (state == ST_FINISH_END) ? 3'd4 : 3'd3;
        3'd3: m_step <= 3'd4;
        3'd4: begin
          m_rst  <= 1'b1;
          m_erst <= (state != ST_FINISH_END);
          m_step <= 3'd5;
        end
        3'd5: begin
          m_done <= 1'b1;
          m_step <= 3'd6;
        end
        default: if (m_restart) begin
          m_done <= 1'b0;
          m_step <= 3'd1;
        end
      endcase
      // own index rules
      if (m_restart) m_idx.raw <= '0;
      else if (m_step == 3'd3) m_idx <= ext_cpu_index;
      else if (ext_cpu_index.raw == m_idx.raw) begin
        if (m_idx.raw == '0 && state == ST_START_BEGIN) m_idx.split.active <= 1'b1;
      end else if (ext_cpu_index.split.active) begin
        if (ext_cpu_msg_in == MSG_END && m_idx.split.active
            && ext_cpu_index.split.pos < m_idx.split.pos)
          m_idx.split.pos <= m_idx.split.pos - 31'd1;
      end else if (ext_cpu_msg_in == MSG_START) begin
        m_idx.split.pos <= m_idx.split.active ? m_idx.split.pos + 31'd1
                                              : m_idx.split.pos - 31'd1;
      end
      // relation, grant and hand-over
      m_ns  <= 1'b0;
      m_msg <= (m_step == 3'd3) ? MSG_RESET : MSG_NONE;
      m_dq  <= m_done && (is_rd(state) || is_wr(state));
      if (ext_next_cpu_q) begin
        if (ext_cpu_index.split.pos < m_idx.split.pos) m_rel <= 2'b01;
        else if (ext_cpu_index.split.pos > m_idx.split.pos) m_rel <= 2'b10;
        else if (ext_cpu_index.raw == m_idx.raw) m_rel <= 2'b11;
      end else if (m_e) m_rel <= 2'b00;
      if (!m_done) begin
        m_online <= 1'b0;
        m_e      <= 1'b0;
      end else if (!bus_busy_in) begin
        if (m_online && (read_q || write_q)) m_e <= 1'b1;
        else if (m_online && m_e) begin
          m_e      <= 1'b0;
          m_online <= 1'b0;
        end
        if (m_grant) begin
          m_online <= 1'b1;
          if (state == ST_WAIT_FOR_START || state == ST_FINISH_BEGIN) begin
            m_ns  <= 1'b1;
            m_e   <= 1'b1;
            m_msg <= (state == ST_WAIT_FOR_START) ? MSG_START : MSG_END;
          end
          if (state == ST_WAIT_FOR_START) begin
            m_base  <= addr_in + THREAD_HEADER_SPACE;
            m_based <= ((data_in != '0) ? data_in : addr_in) + THREAD_HEADER_SPACE;
          end
        end
      end
    end
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles == LIMIT) begin
      $display("run stopped after %0d cycles without finishing", LIMIT);
      $display("*** TEST FAILED ***");
      $finish;
    end
  end

  task automatic check(string what, logic [31:0] exp, logic [31:0] act);
    checks++;
    if (exp !== act) begin
      errors++;
      $display("[FAIL] %s %s: expected %h, actual %h", test_name, what, exp, act);
    end
  endtask

  task automatic compare_outputs();
    check("ext_cpu_msg", 32'(m_msg), 32'(ext_cpu_msg));
    check("next_state", 32'(m_ns), 32'(next_state));
    check("rst", 32'(m_rst), 32'(rst));
    check("ext_rst_e", 32'(m_erst), 32'(ext_rst_e));
    check("bus_busy_out", 32'(m_rst), 32'(bus_busy_out));
    check("disp_online", 32'(m_online), 32'(disp_online));
    check("ext_next_cpu_e", 32'(m_e), 32'(ext_next_cpu_e));
    check("cpu_ind_rel", 32'(m_rel), 32'(cpu_ind_rel));
    check("ext_dispatcher_q", 32'(m_dq), 32'(ext_dispatcher_q));
    check("ext_read_q", 32'(m_online && is_rd(state) && read_q), 32'(ext_read_q));
    check("ext_write_q", 32'(m_online && is_wr(state) && write_q), 32'(ext_write_q));
    check("base_addr", m_base, base_addr);
    check("base_addr_data", m_based, base_addr_data);
  endtask

  // inputs change on the falling edge right after the compare
  task automatic cycle();
    @(posedge clk);
    @(negedge clk);
    compare_outputs();
  endtask

  task automatic end_test();
    tests++;
    $display("test %s done, %0d errors", test_name, errors - test_start_errors);
    test_start_errors = errors;
  endtask

  initial begin
    void'($urandom(32'haefd_aeb7));
    core_states = '{ST_ALU_BEGIN, ST_READ_COND, ST_READ_COND_P, ST_READ_SRC1,
                    ST_READ_SRC1_P, ST_READ_SRC0, ST_READ_SRC0_P, ST_READ_DST,
                    ST_START_READ_CMD, ST_START_READ_CMD_P, ST_WRITE_REG_IP,
                    ST_WRITE_DST, ST_WRITE_DST_P, ST_WRITE_SRC1, ST_WRITE_SRC0,
                    ST_WRITE_COND};
    {errors, checks, tests, test_start_errors} = '0;
    {ext_rst_b, read_q, write_q, ext_next_cpu_q, bus_busy_in} = 5'b10000;
    state = ST_WAIT_FOR_START;
    addr_in = '0;
    data_in = '0;
    ext_cpu_msg_in = MSG_NONE;
    ext_cpu_index = rand_index();
    test_name = "reset_sequence";
    repeat (8) cycle();
    ext_rst_b = 1'b0;
    // token offered while the sequence runs, no grant before seq_done
    ext_next_cpu_q = 1'b1;
    repeat (5) cycle();
    ext_next_cpu_q = 1'b0;
    repeat (2) cycle();
    end_test();

    test_name = "index_tracking";
    state = ST_ALU_BEGIN;
    for (int i = 0; i < 300; i++) begin
      ext_cpu_index = rand_index();
      ext_next_cpu_q = (i % 10 == 9);
      bus_busy_in = ext_next_cpu_q;
      if (ext_next_cpu_q && (i % 40 == 39)) ext_cpu_index = m_idx;
      if (ext_next_cpu_q) ext_cpu_msg_in = MSG_NONE;
      else ext_cpu_msg_in = ($urandom % 3 == 0) ? MSG_NONE : (1'($urandom) ? MSG_START : MSG_END);
      cycle();
    end
    {ext_next_cpu_q, bus_busy_in} = 2'b00;
    ext_cpu_msg_in = MSG_NONE;
    end_test();

    test_name = "start_grant";
    state = ST_WAIT_FOR_START;
    for (int i = 0; i < 4; i++) begin
      addr_in = $urandom;
      data_in = (i % 2 == 0) ? '0 : $urandom;
      ext_cpu_index = m_idx;
      ext_next_cpu_q = 1'b1;
      cycle();
      ext_next_cpu_q = 1'b0;
      repeat (2) cycle();
    end
    end_test();

    test_name = "gating_handover";
    for (int i = 0; i < 200; i++) begin
      state = core_states[4'($urandom)];
      {read_q, write_q} = 2'($urandom);
      ext_cpu_index = ($urandom % 4 == 0) ? m_idx : rand_index();
      ext_next_cpu_q = ($urandom % 8 == 0);
      cycle();
    end
    {read_q, write_q, ext_next_cpu_q} = 3'b000;
    end_test();

    test_name = "finish_rejoin";
    state = ST_FINISH_BEGIN;
    ext_cpu_index = m_idx;
    ext_next_cpu_q = 1'b1;
    cycle();
    ext_next_cpu_q = 1'b0;
    repeat (2) cycle();
    state = ST_FINISH_END;
    repeat (4) cycle();
    // read set state, dispatcher request waits for seq_done
    state = ST_READ_DST;
    repeat (3) cycle();
    ext_cpu_index.raw = '0;
    {ext_next_cpu_q, bus_busy_in} = 2'b11;
    cycle();
    check("rel_zero_index", 32'd3, 32'(cpu_ind_rel));
    end_test();

    test_name = "back_pressure";
    state = ST_WAIT_FOR_START;
    ext_cpu_index = m_idx;
    repeat (3) cycle();
    {ext_next_cpu_q, bus_busy_in} = 2'b00;
    cycle();
    end_test();

    $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
    if (errors == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

// ==== hdl/bridge_top.sv ====
`timescale 1ns/1ns

module bridge_top (
  input  logic                             clk,
  input  logic                             ext_rst_b,
  input  logic [bridge_pkg::STATE_W-1:0]   state,
  input  logic                             read_q,
  input  logic                             write_q,
  input  logic [bridge_pkg::ADDR_W-1:0]    addr_in,
  input  logic [bridge_pkg::DATA_W-1:0]    data_in,
  input  logic                             ext_next_cpu_q,
  input  bridge_pkg::cpu_index_t           ext_cpu_index,
  input  logic [bridge_pkg::CPU_MSG_W-1:0] ext_cpu_msg_in,
  input  logic                             bus_busy_in,
  output logic                             ext_next_cpu_e,
  output logic [bridge_pkg::CPU_MSG_W-1:0] ext_cpu_msg,
  output logic                             ext_read_q,
  output logic                             ext_write_q,
  output logic                             ext_dispatcher_q,
  output logic [1:0]                       cpu_ind_rel,
  output logic                             next_state,
  output logic                             rst,
  output logic                             ext_rst_e,
  output logic                             bus_busy_out,
  output logic                             disp_online,
  output logic [bridge_pkg::ADDR_W-1:0]    base_addr,
  output logic [bridge_pkg::ADDR_W-1:0]    base_addr_data
);

  // sequencer strobes
  logic load_index;
  logic restart;
  logic reset_msg;
  logic seq_done;
  // own index and start grant
  bridge_pkg::cpu_index_t cpu_index;
  logic load_base;

  reset_sequencer u_seq (
    .clk, .ext_rst_b, .state, .rst, .ext_rst_e, .bus_busy_out,
    .load_index, .restart, .reset_msg, .seq_done
  );

  cpu_index_tracker u_tracker (
    .clk, .ext_rst_b, .load_index, .restart, .state,
    .ext_cpu_index, .ext_cpu_msg_in, .cpu_index
  );

  thread_base_regs u_base (
    .clk, .ext_rst_b, .load_base, .addr_in, .data_in, .base_addr, .base_addr_data
  );

  token_arbiter u_arb (
    .clk, .ext_rst_b, .seq_done, .reset_msg, .ext_next_cpu_q, .bus_busy_in,
    .read_q, .write_q, .state, .cpu_index, .ext_cpu_index,
    .ext_next_cpu_e, .disp_online, .next_state, .ext_dispatcher_q, .load_base,
    .ext_read_q, .ext_write_q, .cpu_ind_rel, .ext_cpu_msg
  );

endmodule

// ==== hdl/token_arbiter.sv ====
`timescale 1ns/1ns

module token_arbiter (
  input  logic                             clk,
  input  logic                             ext_rst_b,
  input  logic                             seq_done,
  input  logic                             reset_msg,
  input  logic                             ext_next_cpu_q,
  input  logic                             bus_busy_in,
  input  logic                             read_q,
  input  logic                             write_q,
  input  logic [bridge_pkg::STATE_W-1:0]   state,
  input  bridge_pkg::cpu_index_t           cpu_index,
  input  bridge_pkg::cpu_index_t           ext_cpu_index,
  output logic                             ext_next_cpu_e,
  output logic                             disp_online,
  output logic                             next_state,
  output logic                             ext_dispatcher_q,
  output logic                             load_base,
  output logic                             ext_read_q,
  output logic                             ext_write_q,
  output logic [1:0]                       cpu_ind_rel,
  output logic [bridge_pkg::CPU_MSG_W-1:0] ext_cpu_msg
);

  import bridge_pkg::*;

  logic in_read_set;
  logic in_write_set;
  logic grant;
  logic token_ok;

  assign in_read_set = state inside {ST_READ_COND, ST_READ_COND_P, ST_READ_SRC1,
                                     ST_READ_SRC1_P, ST_READ_SRC0, ST_READ_SRC0_P,
                                     ST_READ_DST, ST_START_READ_CMD, ST_START_READ_CMD_P};
  assign in_write_set = state inside {ST_WRITE_REG_IP, ST_WRITE_DST, ST_WRITE_DST_P,
                                      ST_WRITE_SRC1, ST_WRITE_SRC0, ST_WRITE_COND};

  // token offered to our own index
  assign grant = ext_next_cpu_q && (ext_cpu_index.raw == cpu_index.raw);

  // sequence finished and ring not stalled
  assign token_ok = seq_done && !bus_busy_in;

  // start grant, base regs load on the same edge as MSG_START
  assign load_base = token_ok && grant && (state == ST_WAIT_FOR_START);

  // requests reach the ring only while we own the token
  assign ext_read_q  = disp_online && in_read_set && read_q;
  assign ext_write_q = disp_online && in_write_set && write_q;

  always_ff @(posedge clk) begin
    if (ext_rst_b) begin
      ext_next_cpu_e   <= 1'b0;
      disp_online      <= 1'b0;
      next_state       <= 1'b0;
      ext_dispatcher_q <= 1'b0;
      cpu_ind_rel      <= 2'b00;
      ext_cpu_msg      <= MSG_NONE;
    end else begin
      next_state       <= 1'b0;
      ext_cpu_msg      <= reset_msg ? MSG_RESET : MSG_NONE;
      ext_dispatcher_q <= seq_done && (in_read_set || in_write_set);

      // relation of the offered index to ours, not stalled by bus_busy_in
      if (ext_next_cpu_q) begin
        if (ext_cpu_index.split.pos < cpu_index.split.pos) begin
          cpu_ind_rel <= 2'b01;
        end else if (ext_cpu_index.split.pos > cpu_index.split.pos) begin
          cpu_ind_rel <= 2'b10;
        end else if (ext_cpu_index.raw == cpu_index.raw) begin
          cpu_ind_rel <= 2'b11;
        end
      end else if (ext_next_cpu_e) begin
        cpu_ind_rel <= 2'b00;
      end

      if (!seq_done) begin
        // no token while the sequence runs
        disp_online    <= 1'b0;
        ext_next_cpu_e <= 1'b0;
      end else if (token_ok) begin
        // hand over after the last request is gone
        if (disp_online) begin
          if (read_q || write_q) begin
            ext_next_cpu_e <= 1'b1;
          end else if (ext_next_cpu_e) begin
            ext_next_cpu_e <= 1'b0;
            disp_online    <= 1'b0;
          end
        end
        if (grant) begin
          disp_online <= 1'b1;
          case (state)
            ST_WAIT_FOR_START: begin
              ext_cpu_msg    <= MSG_START;
              next_state     <= 1'b1;
              ext_next_cpu_e <= 1'b1;
            end
            ST_FINISH_BEGIN: begin
              ext_cpu_msg    <= MSG_END;
              next_state     <= 1'b1;
              ext_next_cpu_e <= 1'b1;
            end
            default: begin
              // online only, core drives its own requests
            end
          endcase
        end
      end
    end
  end

endmodule

// ==== hdl/thread_base_regs.sv ====
`timescale 1ns/1ns

module thread_base_regs (
  input  logic                          clk,
  input  logic                          ext_rst_b,
  input  logic                          load_base,
  input  logic [bridge_pkg::ADDR_W-1:0] addr_in,
  input  logic [bridge_pkg::ADDR_W-1:0] data_in,
  output logic [bridge_pkg::ADDR_W-1:0] base_addr,
  output logic [bridge_pkg::ADDR_W-1:0] base_addr_data
);

  import bridge_pkg::*;

  always_ff @(posedge clk) begin
    if (ext_rst_b) begin
      base_addr      <= '0;
      base_addr_data <= '0;
    end else if (load_base) begin
      base_addr <= addr_in + THREAD_HEADER_SPACE;
      // no separate data area, data follows the code header
      if (data_in != '0) begin
        base_addr_data <= data_in + THREAD_HEADER_SPACE;
      end else begin
        base_addr_data <= addr_in + THREAD_HEADER_SPACE;
      end
    end
  end

endmodule

// ==== hdl/cpu_index_tracker.sv ====
`timescale 1ns/1ns

module cpu_index_tracker (
  input  logic                             clk,
  input  logic                             ext_rst_b,
  input  logic                             load_index,
  input  logic                             restart,
  input  logic [bridge_pkg::STATE_W-1:0]   state,
  input  bridge_pkg::cpu_index_t           ext_cpu_index,
  input  logic [bridge_pkg::CPU_MSG_W-1:0] ext_cpu_msg_in,
  output bridge_pkg::cpu_index_t           cpu_index
);

  import bridge_pkg::*;

  logic same_index;
  logic ext_is_lower;

  assign same_index   = (ext_cpu_index.raw == cpu_index.raw);
  assign ext_is_lower = (ext_cpu_index.split.pos < cpu_index.split.pos);

  always_ff @(posedge clk) begin
    if (ext_rst_b) begin
      cpu_index.raw <= '0;
    end else if (restart) begin
      // back to inactive, position zero
      cpu_index.raw <= '0;
    end else if (load_index) begin
      cpu_index <= ext_cpu_index;
    end else if (same_index) begin
      // first thread on the ring becomes active at zero
      if (cpu_index.raw == '0 && state == ST_START_BEGIN) begin
        cpu_index.split.active <= 1'b1;
        cpu_index.split.pos    <= '0;
      end
    end else if (ext_cpu_index.split.active) begin
      // an active sibling below us ended
      if (ext_cpu_msg_in == MSG_END && cpu_index.split.active && ext_is_lower) begin
        cpu_index.split.pos <= cpu_index.split.pos - 1'b1;
      end
    end else begin
      // a new sibling started ahead of the queue
      if (ext_cpu_msg_in == MSG_START) begin
        if (cpu_index.split.active) begin
          cpu_index.split.pos <= cpu_index.split.pos + 1'b1;
        end else begin
          cpu_index.split.pos <= cpu_index.split.pos - 1'b1;
        end
      end
    end
  end

endmodule

// ==== hdl/reset_sequencer.sv ====
`timescale 1ns/1ns

module reset_sequencer (
  input  logic                         clk,
  input  logic                         ext_rst_b,
  input  logic [bridge_pkg::STATE_W-1:0] state,
  output logic                         rst,
  output logic                         ext_rst_e,
  output logic                         bus_busy_out,
  output logic                         load_index,
  output logic                         restart,
  output logic                         reset_msg,
  output logic                         seq_done
);

  import bridge_pkg::*;

  // step 1 clear, 2 check, 3 index load, 4 reset pulses, 5 done, 6 idle
  logic [2:0] step;
  logic       core_finished;

  assign core_finished = (state == ST_FINISH_END);

  // decoded from the step register, consumed on the closing edge of step 3
  assign load_index = (step == 3'd3);
  assign reset_msg  = (step == 3'd3);

  // finished core rejoins the ring
  assign restart = seq_done && core_finished;

  always_ff @(posedge clk) begin
    if (ext_rst_b) begin
      step         <= 3'd1;
      rst          <= 1'b0;
      ext_rst_e    <= 1'b0;
      bus_busy_out <= 1'b0;
      seq_done     <= 1'b0;
    end else begin
      // pulses last a single cycle
      rst          <= 1'b0;
      ext_rst_e    <= 1'b0;
      bus_busy_out <= 1'b0;
      case (step)
        3'd1: begin
          seq_done <= 1'b0;
          step     <= 3'd2;
        end
        3'd2: begin
          // already finished, keep the old index
          step <= core_finished ? 3'd4 : 3'd3;
        end
        3'd3: begin
          step <= 3'd4;
        end
        3'd4: begin
          rst          <= 1'b1;
          bus_busy_out <= 1'b1;
          // ring reset only on a fresh join
          ext_rst_e    <= !core_finished;
          step         <= 3'd5;
        end
        3'd5: begin
          seq_done <= 1'b1;
          step     <= 3'd6;
        end
        default: begin
          if (restart) begin
            seq_done <= 1'b0;
            step     <= 3'd1;
          end
        end
      endcase
    end
  end

endmodule

// ==== hdl/bridge_pkg.sv ====
package bridge_pkg;

  // bus widths
  localparam int ADDR_W = 32;
  localparam int DATA_W = 32;

  // core state code width
  localparam int STATE_W = 6;

  // ring announcement width
  localparam int CPU_MSG_W = 8;

  // core states the bridge reacts to
  localparam logic [STATE_W-1:0] ST_WAIT_FOR_START   = 6'h01;
  localparam logic [STATE_W-1:0] ST_START_BEGIN      = 6'h02;
  localparam logic [STATE_W-1:0] ST_ALU_BEGIN        = 6'h03;
  localparam logic [STATE_W-1:0] ST_FINISH_BEGIN     = 6'h04;
  localparam logic [STATE_W-1:0] ST_FINISH_END       = 6'h05;

  // read set
  localparam logic [STATE_W-1:0] ST_READ_COND        = 6'h10;
  localparam logic [STATE_W-1:0] ST_READ_COND_P      = 6'h11;
  localparam logic [STATE_W-1:0] ST_READ_SRC1        = 6'h12;
  localparam logic [STATE_W-1:0] ST_READ_SRC1_P      = 6'h13;
  localparam logic [STATE_W-1:0] ST_READ_SRC0        = 6'h14;
  localparam logic [STATE_W-1:0] ST_READ_SRC0_P      = 6'h15;
  localparam logic [STATE_W-1:0] ST_READ_DST         = 6'h16;
  localparam logic [STATE_W-1:0] ST_START_READ_CMD   = 6'h17;
  localparam logic [STATE_W-1:0] ST_START_READ_CMD_P = 6'h18;

  // write set
  localparam logic [STATE_W-1:0] ST_WRITE_REG_IP     = 6'h20;
  localparam logic [STATE_W-1:0] ST_WRITE_DST        = 6'h21;
  localparam logic [STATE_W-1:0] ST_WRITE_DST_P      = 6'h22;
  localparam logic [STATE_W-1:0] ST_WRITE_SRC1       = 6'h23;
  localparam logic [STATE_W-1:0] ST_WRITE_SRC0       = 6'h24;
  localparam logic [STATE_W-1:0] ST_WRITE_COND       = 6'h25;

  // announcements on the ring, zero means idle
  localparam logic [CPU_MSG_W-1:0] MSG_NONE  = 8'h00;
  localparam logic [CPU_MSG_W-1:0] MSG_RESET = 8'h01;
  localparam logic [CPU_MSG_W-1:0] MSG_START = 8'h02;
  localparam logic [CPU_MSG_W-1:0] MSG_END   = 8'h03;

  // thread body starts this far past its start address
  localparam logic [ADDR_W-1:0] THREAD_HEADER_SPACE = 32'h0000_0004;

  // thread index, raw word for ring equality, split view for ordering
  typedef union packed {
    logic [DATA_W-1:0] raw;
    struct packed {
      logic              active;
      logic [DATA_W-2:0] pos;
    } split;
  } cpu_index_t;

endpackage
